// File: Makefile
TOP = tb_rv_exec

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f compile.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

// File: compile.f
rv_pkg.sv
reg_file.sv
rv_decoder.sv
rv_alu.sv
rv_lsu.sv
issue_ctrl.sv
rv_exec_top.sv
tb_commit_checker.sv
tb_rv_exec.sv

// File: issue_ctrl.sv
`timescale 1ns/1ns

module issue_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  logic [rv_pkg::reg_addr_width-1:0] rd,
    input  logic                              writes_rd,
    input  logic                              illegal,
    input  rv_pkg::mem_op_e                   mem_op,
    input  logic [rv_pkg::xlen-1:0]           alu_result,
    input  logic [rv_pkg::xlen-1:0]           load_data,
    output logic                              access,
    output logic                              wen,
    output logic [rv_pkg::reg_addr_width-1:0] waddr,
    output logic [rv_pkg::xlen-1:0]           wdata,
    output logic                              commit_valid,
    output logic [rv_pkg::reg_addr_width-1:0] commit_rd,
    output logic [rv_pkg::xlen-1:0]           commit_data,
    output logic                              commit_illegal
);

    typedef enum logic {
        st_idle,
        st_load_wait
    } state_e;

    state_e                            state;
    state_e                            state_next;
    logic                              ready_q;
    logic                              accept;
    logic                              is_load;
    logic [rv_pkg::reg_addr_width-1:0] rd_q;     // load destination

    assign accept   = in_valid && in_ready;
    assign is_load  = (mem_op == rv_pkg::mem_load_d) || (mem_op == rv_pkg::mem_load_w);
    assign access   = accept && (mem_op != rv_pkg::mem_none);
    assign in_ready = ready_q;

    assign state_next = (state == st_idle && accept && is_load) ? st_load_wait : st_idle;

    // alu results at acceptance, load data one cycle later
    assign wen   = (state == st_load_wait) || (accept && writes_rd && !is_load);
    assign waddr = (state == st_load_wait) ? rd_q : rd;
    assign wdata = (state == st_load_wait) ? load_data : alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_idle;
            ready_q      <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            state        <= state_next;
            ready_q      <= (state_next == st_idle); // drops for one cycle per load
            commit_valid <= (state == st_load_wait) || (accept && !is_load);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_q <= rd;
        end
        if (state == st_load_wait) begin
            commit_rd      <= rd_q;
            commit_data    <= load_data;
            commit_illegal <= 1'b0;
        end else if (accept) begin
            commit_rd      <= writes_rd ? rd : '0; // stores and illegals report x0
            commit_data    <= writes_rd ? alu_result : '0;
            commit_illegal <= illegal;
        end
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              wen,
    input  logic [rv_pkg::reg_addr_width-1:0] waddr,
    input  logic [rv_pkg::reg_addr_width-1:0] raddr1,
    input  logic [rv_pkg::reg_addr_width-1:0] raddr2,
    input  logic [rv_pkg::xlen-1:0]           wdata,
    output logic [rv_pkg::xlen-1:0]           rdata1,
    output logic [rv_pkg::xlen-1:0]           rdata2
);

    logic [rv_pkg::xlen-1:0] regs [rv_pkg::reg_depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_pkg::reg_depth; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    // read port 1
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    // read port 2
    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

// File: rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
    input  logic [rv_pkg::xlen-1:0] op_a,
    input  logic [rv_pkg::xlen-1:0] op_b,
    input  rv_pkg::alu_op_e         alu_op,
    output logic [rv_pkg::xlen-1:0] result
);

    logic [31:0] sum_w; // low-word sum for addw

    assign sum_w = op_a[31:0] + op_b[31:0];

    always_comb begin
        case (alu_op)
            rv_pkg::alu_add: begin
                result = op_a + op_b;
            end
            rv_pkg::alu_sub: begin
                result = op_a - op_b;
            end
            rv_pkg::alu_and: begin
                result = op_a & op_b;
            end
            rv_pkg::alu_or: begin
                result = op_a | op_b;
            end
            rv_pkg::alu_xor: begin
                result = op_a ^ op_b;
            end
            rv_pkg::alu_addw: begin
                result = {{32{sum_w[31]}}, sum_w}; // sign-extend bit 31
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
    input  logic [31:0]                       instr,
    output logic [rv_pkg::reg_addr_width-1:0] rs1,
    output logic [rv_pkg::reg_addr_width-1:0] rs2,
    output logic [rv_pkg::reg_addr_width-1:0] rd,
    output logic [rv_pkg::xlen-1:0]           imm,
    output logic                              use_imm,
    output rv_pkg::alu_op_e                   alu_op,
    output rv_pkg::mem_op_e                   mem_op,
    output logic                              writes_rd,
    output logic                              illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // s-type splits the offset around rd
    assign imm = (opcode == rv_pkg::opc_store) ?
                 {{52{instr[31]}}, instr[31:25], instr[11:7]} :
                 {{52{instr[31]}}, instr[31:20]};

    always_comb begin
        use_imm   = 1'b0;
        alu_op    = rv_pkg::alu_add;
        mem_op    = rv_pkg::mem_none;
        writes_rd = 1'b0;
        illegal   = 1'b1; // cleared on a match
        case (opcode)
            rv_pkg::opc_op: begin
                writes_rd = 1'b1;
                illegal   = 1'b0;
                if (funct7 == rv_pkg::f7_base && funct3 == rv_pkg::f3_add_sub) alu_op = rv_pkg::alu_add;
                else if (funct7 == rv_pkg::f7_sub && funct3 == rv_pkg::f3_add_sub) alu_op = rv_pkg::alu_sub;
                else if (funct7 == rv_pkg::f7_base && funct3 == rv_pkg::f3_and) alu_op = rv_pkg::alu_and;
                else if (funct7 == rv_pkg::f7_base && funct3 == rv_pkg::f3_or) alu_op = rv_pkg::alu_or;
                else if (funct7 == rv_pkg::f7_base && funct3 == rv_pkg::f3_xor) alu_op = rv_pkg::alu_xor;
                else begin
                    writes_rd = 1'b0;
                    illegal   = 1'b1;
                end
            end
            rv_pkg::opc_op_imm: begin
                if (funct3 == rv_pkg::f3_add_sub) begin // addi only
                    use_imm   = 1'b1;
                    writes_rd = 1'b1;
                    illegal   = 1'b0;
                end
            end
            rv_pkg::opc_op_32: begin
                if (funct7 == rv_pkg::f7_base && funct3 == rv_pkg::f3_add_sub) begin
                    alu_op    = rv_pkg::alu_addw;
                    writes_rd = 1'b1;
                    illegal   = 1'b0;
                end
            end
            rv_pkg::opc_load: begin
                use_imm = 1'b1; // address = rs1 + imm
                if (funct3 == rv_pkg::f3_dword || funct3 == rv_pkg::f3_word) begin
                    mem_op    = (funct3 == rv_pkg::f3_dword) ? rv_pkg::mem_load_d : rv_pkg::mem_load_w;
                    writes_rd = 1'b1;
                    illegal   = 1'b0;
                end
            end
            rv_pkg::opc_store: begin
                use_imm = 1'b1;
                if (funct3 == rv_pkg::f3_dword || funct3 == rv_pkg::f3_word) begin
                    mem_op  = (funct3 == rv_pkg::f3_dword) ? rv_pkg::mem_store_d : rv_pkg::mem_store_w;
                    illegal = 1'b0;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: rv_exec_top.sv
`timescale 1ns/1ns

module rv_exec_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  logic [31:0]                       in_instr,
    output logic                              commit_valid,
    output logic [rv_pkg::reg_addr_width-1:0] commit_rd,
    output logic [rv_pkg::xlen-1:0]           commit_data,
    output logic                              commit_illegal
);

    logic [rv_pkg::reg_addr_width-1:0] rs1;
    logic [rv_pkg::reg_addr_width-1:0] rs2;
    logic [rv_pkg::reg_addr_width-1:0] rd;
    logic [rv_pkg::reg_addr_width-1:0] waddr;
    logic [rv_pkg::xlen-1:0]           imm;
    logic [rv_pkg::xlen-1:0]           rdata1;
    logic [rv_pkg::xlen-1:0]           rdata2;
    logic [rv_pkg::xlen-1:0]           op_b;
    logic [rv_pkg::xlen-1:0]           alu_result;
    logic [rv_pkg::xlen-1:0]           load_data;
    logic [rv_pkg::xlen-1:0]           wdata;
    logic                              use_imm;
    logic                              writes_rd;
    logic                              illegal;
    logic                              access;
    logic                              wen;
    rv_pkg::alu_op_e                   alu_op;
    rv_pkg::mem_op_e                   mem_op;

    assign op_b = use_imm ? imm : rdata2; // immediate or rs2

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (wen),
        .waddr  (waddr),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    rv_decoder u_decoder (
        .instr     (in_instr),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .use_imm   (use_imm),
        .alu_op    (alu_op),
        .mem_op    (mem_op),
        .writes_rd (writes_rd),
        .illegal   (illegal)
    );

    rv_alu u_alu (
        .op_a   (rdata1),
        .op_b   (op_b),
        .alu_op (alu_op),
        .result (alu_result)
    );

    rv_lsu u_lsu (
        .clk        (clk),
        .access     (access),
        .mem_op     (mem_op),
        .addr       (alu_result), // rs1 + imm
        .store_data (rdata2),
        .load_data  (load_data)
    );

    issue_ctrl u_issue_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .rd             (rd),
        .writes_rd      (writes_rd),
        .illegal        (illegal),
        .mem_op         (mem_op),
        .alu_result     (alu_result),
        .load_data      (load_data),
        .access         (access),
        .wen            (wen),
        .waddr          (waddr),
        .wdata          (wdata),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_illegal (commit_illegal)
    );

endmodule

// File: rv_lsu.sv
`timescale 1ns/1ns

module rv_lsu (
    input  logic                    clk,
    input  logic                    access,
    input  rv_pkg::mem_op_e         mem_op,
    input  logic [rv_pkg::xlen-1:0] addr,
    input  logic [rv_pkg::xlen-1:0] store_data,
    output logic [rv_pkg::xlen-1:0] load_data
);

    logic [rv_pkg::xlen-1:0]            mem [2**rv_pkg::mem_index_width];
    logic [rv_pkg::mem_index_width-1:0] index;
    logic [7:0]                         wmask;
    logic [rv_pkg::xlen-1:0]            wdata;
    logic                               is_store;
    logic [rv_pkg::xlen-1:0]            rdata_q;  // addressed doubleword
    logic                               word_q;   // lw pending
    logic                               half_q;   // upper word selected

    assign index    = addr[10:3];
    assign is_store = (mem_op == rv_pkg::mem_store_d) || (mem_op == rv_pkg::mem_store_w);

    always_comb begin
        if (mem_op == rv_pkg::mem_store_w) begin
            wmask = addr[2] ? 8'hf0 : 8'h0f;
            wdata = {store_data[31:0], store_data[31:0]}; // word in both halves
        end else begin
            wmask = 8'hff;
            wdata = store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (is_store) begin
                for (int b = 0; b < 8; b++) begin
                    if (wmask[b]) begin
                        mem[index][b*8 +: 8] <= wdata[b*8 +: 8];
                    end
                end
            end else begin
                rdata_q <= mem[index];
                word_q  <= (mem_op == rv_pkg::mem_load_w);
                half_q  <= addr[2];
            end
        end
    end

    // align and sign-extend for lw
    always_comb begin
        if (word_q) begin
            if (half_q) begin
                load_data = {{32{rdata_q[63]}}, rdata_q[63:32]};
            end else begin
                load_data = {{32{rdata_q[31]}}, rdata_q[31:0]};
            end
        end else begin
            load_data = rdata_q;
        end
    end

endmodule

// File: rv_pkg.sv
package rv_pkg;

    localparam int xlen            = 64; // data width
    localparam int reg_addr_width  = 5;
    localparam int reg_depth       = 32;
    localparam int mem_index_width = 8;  // 256 doublewords

    // major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op_32  = 7'b0111011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    // access sizes for loads and stores
    localparam logic [2:0] f3_word  = 3'b010;
    localparam logic [2:0] f3_dword = 3'b011;

    // alu funct3 / funct7
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [6:0] f7_base    = 7'b0000000;
    localparam logic [6:0] f7_sub     = 7'b0100000;

    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_and  = 3'd2,
        alu_or   = 3'd3,
        alu_xor  = 3'd4,
        alu_addw = 3'd5
    } alu_op_e;

    typedef enum logic [2:0] {
        mem_none    = 3'd0,
        mem_load_d  = 3'd1,
        mem_load_w  = 3'd2,
        mem_store_d = 3'd3,
        mem_store_w = 3'd4
    } mem_op_e;

endpackage

// File: tb_commit_checker.sv
`timescale 1ns/1ns

module tb_commit_checker (
    input logic        clk,
    input logic        rst_n,
    input logic        in_valid,
    input logic        in_ready,
    input logic [31:0] in_instr,
    input logic        commit_valid,
    input logic [4:0]  commit_rd,
    input logic [63:0] commit_data,
    input logic        commit_illegal
);

    string       name_q [$]; // expected commits, oldest first
    logic [4:0]  rd_q [$];
    logic [63:0] data_q [$];
    logic        ill_q [$];
    int          commit_checks = 0;
    int          commit_errors = 0;
    int          ready_checks  = 0;
    int          ready_errors  = 0;
    logic        load_p1;      // load accepted one edge ago
    logic        load_p2;      // load accepted two edges ago
    logic        is_load;

    assign is_load = (in_instr[6:0] == rv_pkg::opc_load) &&
                     (in_instr[14:12] == rv_pkg::f3_word || in_instr[14:12] == rv_pkg::f3_dword);

    task automatic push_expect(input string name, input logic [4:0] rd,
                               input logic [63:0] data, input logic ill);
        name_q.push_back(name);
        rd_q.push_back(rd);
        data_q.push_back(data);
        ill_q.push_back(ill);
    endtask

    function automatic int pending();
        return rd_q.size();
    endfunction

    function automatic int checks();
        return commit_checks + ready_checks;
    endfunction

    function automatic int errors();
        return commit_errors + ready_errors;
    endfunction

    task automatic compare_field(input string name, input string field,
                                 input logic [63:0] expected, input logic [63:0] actual);
        commit_checks++;
        if (actual !== expected) begin
            commit_errors++;
            $display("Mismatch %s (%s): expected %h actual %h", name, field, expected, actual);
        end
    endtask

    // sampled before the edge, so values are the ones held during the cycle
    always @(posedge clk) begin : commit_compare
        string       name;
        logic [4:0]  e_rd;
        logic [63:0] e_data;
        logic        e_ill;
        if (rst_n && commit_valid) begin
            if (rd_q.size() == 0) begin
                commit_errors++;
                $display("commit for rd %0d arrived with no instruction outstanding", commit_rd);
            end else begin
                name   = name_q.pop_front();
                e_rd   = rd_q.pop_front();
                e_data = data_q.pop_front();
                e_ill  = ill_q.pop_front();
                compare_field(name, "rd", 64'(e_rd), 64'(commit_rd));
                compare_field(name, "data", e_data, commit_data);
                compare_field(name, "illegal", 64'(e_ill), 64'(commit_illegal));
            end
        end
    end

    // in_ready must drop for exactly one cycle after a load
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_p1 <= 1'b0;
            load_p2 <= 1'b0;
        end else begin
            if (load_p1) begin
                ready_checks++;
                if (in_ready) begin
                    ready_errors++;
                    $display("in_ready stayed high in the cycle after a load was accepted");
                end
            end
            if (load_p2) begin
                ready_checks++;
                if (!in_ready) begin
                    ready_errors++;
                    $display("in_ready stayed low for more than one cycle after a load");
                end
            end
            load_p1 <= in_valid && in_ready && is_load;
            load_p2 <= load_p1;
        end
    end

endmodule

// File: tb_rv_exec.sv
`timescale 1ns/1ns

module tb_rv_exec;

    localparam int timeout_cycles = 100;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_instr;
    logic        commit_valid;
    logic [4:0]  commit_rd;
    logic [63:0] commit_data;
    logic        commit_illegal;

    logic [63:0] ref_regs [32];  // architectural register model
    logic [63:0] ref_mem [256];  // data memory model
    int          tb_errors;

    rv_exec_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_instr       (in_instr),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_illegal (commit_illegal)
    );

    tb_commit_checker chk (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_instr       (in_instr),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_illegal (commit_illegal)
    );

    always #4 clk = ~clk;

    // ISA reference: returns the commit an instruction should produce
    function automatic void model_step(input logic [31:0] instr, output logic [4:0] e_rd,
                                       output logic [63:0] e_data, output logic e_ill);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] addr;
        logic [31:0] word;
        logic [7:0]  idx;
        logic        writes;
        opc    = instr[6:0];
        f3     = instr[14:12];
        f7     = instr[31:25];
        a      = ref_regs[instr[19:15]];
        b      = ref_regs[instr[24:20]];
        e_rd   = instr[11:7];
        e_data = '0;
        e_ill  = 1'b0;
        writes = 1'b1;
        if (opc == rv_pkg::opc_op && f3 == 3'b000 && f7 == 7'h00) begin
            e_data = a + b;
        end else if (opc == rv_pkg::opc_op && f3 == 3'b000 && f7 == 7'h20) begin
            e_data = a - b;
        end else if (opc == rv_pkg::opc_op && f3 == 3'b111 && f7 == 7'h00) begin
            e_data = a & b;
        end else if (opc == rv_pkg::opc_op && f3 == 3'b110 && f7 == 7'h00) begin
            e_data = a | b;
        end else if (opc == rv_pkg::opc_op && f3 == 3'b100 && f7 == 7'h00) begin
            e_data = a ^ b;
        end else if (opc == rv_pkg::opc_op_imm && f3 == 3'b000) begin
            e_data = a + {{52{instr[31]}}, instr[31:20]};
        end else if (opc == rv_pkg::opc_op_32 && f3 == 3'b000 && f7 == 7'h00) begin
            word   = a[31:0] + b[31:0];
            e_data = {{32{word[31]}}, word};
        end else if (opc == rv_pkg::opc_load && (f3 == 3'b011 || f3 == 3'b010)) begin
            addr = a + {{52{instr[31]}}, instr[31:20]};
            idx  = addr[10:3];
            word = addr[2] ? ref_mem[idx][63:32] : ref_mem[idx][31:0];
            e_data = (f3 == 3'b011) ? ref_mem[idx] : {{32{word[31]}}, word};
        end else if (opc == rv_pkg::opc_store && (f3 == 3'b011 || f3 == 3'b010)) begin
            addr = a + {{52{instr[31]}}, instr[31:25], instr[11:7]};
            idx  = addr[10:3];
            if (f3 == 3'b011) begin
                ref_mem[idx] = b;
            end else if (addr[2]) begin
                ref_mem[idx][63:32] = b[31:0];
            end else begin
                ref_mem[idx][31:0] = b[31:0];
            end
            e_rd   = '0;
            writes = 1'b0;
        end else begin
            e_rd   = '0;
            e_ill  = 1'b1;
            writes = 1'b0;
        end
        if (writes && e_rd != 0) begin
            ref_regs[e_rd] = e_data;
        end
    endfunction

    task automatic abort_run(input string msg);
        tb_errors++;
        $display("%s", msg);
        $display("checks %0d, errors %0d", chk.checks(), chk.errors() + tb_errors);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_instr(input string name, input logic [31:0] instr);
        int          waited;
        logic [4:0]  e_rd;
        logic [63:0] e_data;
        logic        e_ill;
        waited   = 0;
        in_valid = 1'b1;
        in_instr = instr;
        while (!in_ready) begin
            @(negedge clk);
            waited++;
            if (waited > timeout_cycles) begin
                abort_run($sformatf("timeout: in_ready never rose for %s", name));
            end
        end
        model_step(instr, e_rd, e_data, e_ill); // transfer happens at the next rising edge
        chk.push_expect(name, e_rd, e_data, e_ill);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic reg_op(input string name, input logic [6:0] f7, input logic [2:0] f3,
                          input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        send_instr(name, {f7, rs2, rs1, f3, rd, rv_pkg::opc_op});
    endtask

    task automatic add_word(input string name, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [4:0] rs2);
        send_instr(name, {7'h00, rs2, rs1, 3'b000, rd, rv_pkg::opc_op_32});
    endtask

    task automatic add_imm(input string name, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [11:0] imm);
        send_instr(name, {imm, rs1, 3'b000, rd, rv_pkg::opc_op_imm});
    endtask

    task automatic load_op(input string name, input logic [2:0] f3, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [11:0] imm);
        send_instr(name, {imm, rs1, f3, rd, rv_pkg::opc_load});
    endtask

    task automatic store_op(input string name, input logic [2:0] f3, input logic [4:0] rs2,
                            input logic [4:0] rs1, input logic [11:0] imm);
        send_instr(name, {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::opc_store});
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    initial begin
        int          i;
        int          kind;
        int          waited;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [2:0]  sel;
        logic [11:0] off;
        logic [6:0]  op_f7 [8];
        logic [2:0]  op_f3 [8];
        void'($urandom(4128));
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        tb_errors = 0;
        ref_regs  = '{default: '0};
        op_f7 = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00}; // add sub and or xor
        op_f3 = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b000, 3'b000, 3'b100};
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // register ops, x0 reads and writes
        for (i = 1; i < 32; i++) begin
            add_imm("addi init", 5'(i), 5'd0, 12'($urandom));
        end
        for (i = 0; i < 24; i++) begin
            sel = 3'(i);
            reg_op("reg op", op_f7[sel], op_f3[sel], 5'($urandom % 31 + 1),
                   5'($urandom % 32), 5'($urandom % 32));
        end
        reg_op("x0 read", 7'h00, 3'b000, 5'd7, 5'd0, 5'd3);
        add_imm("x0 write", 5'd0, 5'd4, 12'h055);
        reg_op("x0 after write", 7'h00, 3'b110, 5'd8, 5'd0, 5'd0);

        // addw, x9 doubled up to 0x7ff00000
        add_imm("addw setup", 5'd9, 5'd0, 12'h7ff);
        for (i = 0; i < 20; i++) begin
            reg_op("addw setup", 7'h00, 3'b000, 5'd9, 5'd9, 5'd9);
        end
        add_word("addw overflow", 5'd10, 5'd9, 5'd9);
        reg_op("add without wrap", 7'h00, 3'b000, 5'd11, 5'd9, 5'd9);
        add_word("addw carry out", 5'd12, 5'd10, 5'd9);

        // memory: fill 8 doublewords above base 0x100, then sd/ld and sw merge
        add_imm("lsu base", 5'd20, 5'd0, 12'h100);
        for (i = 0; i < 8; i++) begin
            add_imm("fill value", 5'd21, 5'd0, 12'((256 + i * 8) ^ 'h3c5));
            reg_op("fill value", 7'h00, 3'b100, 5'd21, 5'd21, 5'd10);
            store_op("fill", 3'b011, 5'd21, 5'd20, 12'(i * 8));
        end
        store_op("sd then ld", 3'b011, 5'd11, 5'd20, 12'd0);
        load_op("sd then ld", 3'b011, 5'd15, 5'd20, 12'd0);
        store_op("sw low half", 3'b010, 5'd3, 5'd20, 12'd8);
        store_op("sw high half", 3'b010, 5'd10, 5'd20, 12'd12);
        load_op("ld merged", 3'b011, 5'd16, 5'd20, 12'd8);
        load_op("lw low", 3'b010, 5'd17, 5'd20, 12'd8);
        load_op("lw high", 3'b010, 5'd18, 5'd20, 12'd12);

        // random mix with gaps on in_valid
        for (i = 0; i < 300; i++) begin
            rd   = 5'($urandom % 16);
            rs1  = 5'($urandom % 16);
            rs2  = 5'($urandom % 16);
            sel  = 3'($urandom);
            kind = $urandom % 9;
            f3   = ($urandom % 2 != 0) ? 3'b011 : 3'b010;
            off  = 12'(($urandom % 8) * 8);
            if (f3 == 3'b010 && $urandom % 2 != 0) begin
                off = off + 12'd4; // upper word
            end
            if (kind < 5) begin
                reg_op("random reg op", op_f7[sel], op_f3[sel], rd, rs1, rs2);
            end else if (kind == 5) begin
                add_word("random addw", rd, rs1, rs2);
            end else if (kind == 6) begin
                add_imm("random addi", rd, rs1, 12'($urandom));
            end else if (kind == 7) begin
                load_op("random load", f3, rd, 5'd20, off);
            end else begin
                store_op("random store", f3, rs2, 5'd20, off);
            end
            if ($urandom % 4 == 0) begin
                idle_cycles($urandom % 3 + 1);
            end
        end

        // unsupported encodings leave x5 alone
        send_instr("illegal mul", {7'h01, 5'd2, 5'd3, 3'b000, 5'd5, rv_pkg::opc_op});
        send_instr("illegal opcode", {20'h12345, 5'd5, 7'h7f});
        send_instr("illegal shift", {12'd3, 5'd5, 3'b001, 5'd5, rv_pkg::opc_op_imm});
        reg_op("read after illegal", 7'h00, 3'b110, 5'd6, 5'd5, 5'd0);

        idle_cycles(2);
        waited = 0;
        while (chk.pending() != 0 && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (chk.pending() != 0) begin
            tb_errors++;
            $display("%0d accepted instructions never committed", chk.pending());
        end
        $display("checks %0d, errors %0d", chk.checks(), chk.errors() + tb_errors);
        if (chk.errors() + tb_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
